//--- Bender.yml
package:
  name: input_board

sources:
  - src/board_pkg.sv
  - src/joy_4way.sv
  - src/joy_mapper.sv
  - src/board_ctrl.sv
  - src/input_board_top.sv
  - target: test
    files:
      - bench/tb_input_board.sv

//--- bench/tb_input_board.sv
// testbench for the player input board
// applies random and directed input steps, holds each one for six cycles
// and checks every output against a reference model of the board rules

`timescale 1ns/1ps

module tb_input_board
    import board_pkg::*;
();

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 16;
    localparam int SETTLE_CYCLES = 5;
    localparam int BUTTONS       = 2;
    localparam int START_POS     = BUTTONS + 4;
    localparam int COIN_POS      = BUTTONS + 5;
    localparam int PAUSE_POS     = BUTTONS + 6;

    localparam int N_PLAIN  = 40;
    localparam int N_ROT    = 30;
    localparam int N_FOUR   = 40;
    localparam int N_SEQ    = 9;
    localparam int N_PAUSE  = 12;
    localparam int N_MIX    = 40;
    localparam int TOTAL_STEPS = N_PLAIN + 2 * N_ROT + N_FOUR + N_SEQ + N_PAUSE + N_MIX;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TOTAL_STEPS * 10 + 100;

    logic               clk_sys;
    logic               rst;
    joy_word_t          board_joy [PLAYERS];
    game_joy_t          key_joy [PLAYERS];
    logic [PLAYERS-1:0] key_start;
    logic [PLAYERS-1:0] key_coin;
    logic               key_reset;
    logic               key_pause;
    logic               key_service;
    logic [GFX_W-1:0]   key_gfx;
    logic               four_way;
    logic               rot_control;
    logic               flip;
    logic               osd_pause;
    logic               downloading;

    game_joy_t          game_joystick1;
    game_joy_t          game_joystick2;
    game_joy_t          game_joystick3;
    game_joy_t          game_joystick4;
    logic [PLAYERS-1:0] game_coin;
    logic [PLAYERS-1:0] game_start;
    logic               game_service;
    logic               game_pause;
    logic               soft_rst;
    logic [GFX_W-1:0]   gfx_en;

    int          errors = 0;
    int          checks = 0;
    int          steps_applied = 0;
    int          steps_checked = 0;
    int          pulse_count = 0;
    int          pulses_seen = 0;
    logic [31:0] lfsr_state = 32'h623d_08a0;

    // model state and the inputs of the step before
    dir_t             last_dir [PLAYERS];
    logic             exp_pause;
    logic [GFX_W-1:0] exp_gfx;
    joy_word_t        prev_board [PLAYERS];
    game_joy_t        prev_key [PLAYERS];
    logic             prev_key_pause;
    logic             prev_osd;
    logic             prev_key_reset;
    logic [GFX_W-1:0] prev_gfx;

    input_board_top input_board_top_inst (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .board_joystick1 (board_joy[0]),
        .board_joystick2 (board_joy[1]),
        .board_joystick3 (board_joy[2]),
        .board_joystick4 (board_joy[3]),
        .key_joy1        (key_joy[0]),
        .key_joy2        (key_joy[1]),
        .key_joy3        (key_joy[2]),
        .key_joy4        (key_joy[3]),
        .key_start       (key_start),
        .key_coin        (key_coin),
        .key_reset       (key_reset),
        .key_pause       (key_pause),
        .key_service     (key_service),
        .key_gfx         (key_gfx),
        .four_way        (four_way),
        .rot_control     (rot_control),
        .flip            (flip),
        .osd_pause       (osd_pause),
        .downloading     (downloading),
        .game_joystick1  (game_joystick1),
        .game_joystick2  (game_joystick2),
        .game_joystick3  (game_joystick3),
        .game_joystick4  (game_joystick4),
        .game_coin       (game_coin),
        .game_start      (game_start),
        .game_service    (game_service),
        .game_pause      (game_pause),
        .soft_rst        (soft_rst),
        .gfx_en          (gfx_en)
    );

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic int count_dirs(input dir_t d);
        int i;
        int n;
        n = 0;
        for (i = 0; i < DIR_W; i++) begin
            n += d[i];
        end
        return n;
    endfunction

    // steady output of the 4-way filter for a held input
    function automatic dir_t filter_4way(input dir_t d, input dir_t last);
        if (count_dirs(d) <= 1) begin
            return d;
        end
        return ((d & last) != '0) ? last : '0;
    endfunction

    // game word from filtered directions, keys, rotation and active-low output
    function automatic game_joy_t expect_joy(input joy_word_t board, input game_joy_t key,
                                             input dir_t dirs, input logic rot, input logic fl);
        game_joy_t w;
        game_joy_t r;
        w = {board[GAME_JOY_W-1:DIR_W], dirs} | key;
        r = w;
        if (rot && fl) begin
            r[3] = w[1];
            r[2] = w[0];
            r[1] = w[2];
            r[0] = w[3];
        end else if (rot) begin
            r[3] = w[0];
            r[2] = w[1];
            r[1] = w[3];
            r[0] = w[2];
        end
        return ~r;
    endfunction

    function automatic logic next_pause(input logic cur, input logic dl, input logic osd_chg,
                                        input logic osd, input logic tog);
        if (dl) begin
            return 1'b0;
        end else if (osd_chg) begin
            return osd;
        end
        return tog ? ~cur : cur;
    endfunction

    function automatic game_joy_t game_joy_of(input int p);
        case (p)
            0: return game_joystick1;
            1: return game_joystick2;
            2: return game_joystick3;
            default: return game_joystick4;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_step();
        int                 p;
        dir_t               dirs;
        logic [PLAYERS-1:0] exp_start;
        logic [PLAYERS-1:0] exp_coin;
        logic               exp_service;
        logic               j0;
        logic               j1;
        logic               j2;
        logic               exp_pulse;
        for (p = 0; p < PLAYERS; p++) begin
            dirs = board_joy[p][DIR_W-1:0];
            if (four_way) begin
                if (count_dirs(dirs) == 1) begin
                    last_dir[p] = dirs;
                end
                dirs = filter_4way(dirs, last_dir[p]);
            end
            check_value($sformatf("game_joystick%0d", p + 1),
                        expect_joy(board_joy[p], key_joy[p], dirs, rot_control, flip),
                        game_joy_of(p));
            exp_start[p] = ~(board_joy[p][START_POS] | key_joy[p][START_POS] | key_start[p]);
            exp_coin[p]  = ~(board_joy[p][COIN_POS] | key_joy[p][COIN_POS] | key_coin[p]);
        end
        exp_service = ~key_service;
        check_value("game_start", exp_start, game_start);
        check_value("game_coin", exp_coin, game_coin);
        check_value("game_service", exp_service, game_service);
        // keys reach the player pause bit one cycle before board bits do
        j0 = prev_board[0][PAUSE_POS] | prev_key[0][PAUSE_POS]
           | prev_board[1][PAUSE_POS] | prev_key[1][PAUSE_POS];
        j1 = prev_board[0][PAUSE_POS] | key_joy[0][PAUSE_POS]
           | prev_board[1][PAUSE_POS] | key_joy[1][PAUSE_POS];
        j2 = board_joy[0][PAUSE_POS] | key_joy[0][PAUSE_POS]
           | board_joy[1][PAUSE_POS] | key_joy[1][PAUSE_POS];
        exp_pause = next_pause(exp_pause, downloading, osd_pause != prev_osd, osd_pause,
                               key_pause && !prev_key_pause);
        exp_pause = next_pause(exp_pause, downloading, 1'b0, osd_pause, j1 && !j0);
        exp_pause = next_pause(exp_pause, downloading, 1'b0, osd_pause, j2 && !j1);
        check_value("game_pause", exp_pause, game_pause);
        exp_gfx = exp_gfx ^ (key_gfx & ~prev_gfx);
        check_value("gfx_en", exp_gfx, gfx_en);
        exp_pulse = key_reset && !prev_key_reset;
        check_value("soft_rst pulse count", exp_pulse, pulse_count - pulses_seen);
        check_value("soft_rst", 1'b0, soft_rst);
        pulses_seen = pulse_count;
        for (p = 0; p < PLAYERS; p++) begin
            prev_board[p] = board_joy[p];
            prev_key[p]   = key_joy[p];
        end
        prev_key_pause = key_pause;
        prev_osd       = osd_pause;
        prev_key_reset = key_reset;
        prev_gfx       = key_gfx;
    endtask

    task automatic clear_inputs();
        int p;
        for (p = 0; p < PLAYERS; p++) begin
            board_joy[p] = '0;
            key_joy[p]   = '0;
        end
        key_start   = '0;
        key_coin    = '0;
        key_reset   = 1'b0;
        key_pause   = 1'b0;
        key_service = 1'b0;
        key_gfx     = '0;
        osd_pause   = 1'b0;
        downloading = 1'b0;
    endtask

    task automatic drive_random();
        int          p;
        logic [31:0] bits;
        for (p = 0; p < PLAYERS; p++) begin
            take_bits(JOY_W, bits);
            board_joy[p] = bits[JOY_W-1:0];
            take_bits(GAME_JOY_W, bits);
            key_joy[p] = bits[GAME_JOY_W-1:0];
        end
        take_bits(PLAYERS, bits);
        key_start = bits[PLAYERS-1:0];
        take_bits(PLAYERS, bits);
        key_coin = bits[PLAYERS-1:0];
        take_bits(4, bits);
        {key_reset, key_pause, key_service, osd_pause} = bits[3:0];
        take_bits(GFX_W, bits);
        key_gfx = bits[GFX_W-1:0];
        // downloading on about one step in four
        take_bits(2, bits);
        downloading = &bits[1:0];
    endtask

    // hands the step to the compare process and waits for its checks
    task automatic launch_step();
        steps_applied++;
        wait (steps_checked == steps_applied);
    endtask

    task automatic random_steps(input int n, input logic fw, input logic rot, input logic fl);
        int i;
        for (i = 0; i < n; i++) begin
            @(negedge clk_sys);
            drive_random();
            four_way    = fw;
            rot_control = rot;
            flip        = fl;
            launch_step();
        end
    endtask

    task automatic pause_step(input logic kp, input logic p2, input logic osd, input logic dl);
        @(negedge clk_sys);
        clear_inputs();
        key_pause               = kp;
        board_joy[1][PAUSE_POS] = p2;
        osd_pause               = osd;
        downloading             = dl;
        launch_step();
    endtask

    always @(negedge clk_sys) begin
        if (soft_rst === 1'b1) begin
            pulse_count++;
        end
    end

    initial begin : compare
        int p;
        for (p = 0; p < PLAYERS; p++) begin
            last_dir[p]   = '0;
            prev_board[p] = '0;
            prev_key[p]   = '0;
        end
        exp_pause      = 1'b0;
        exp_gfx        = {GFX_W{1'b1}};
        prev_key_pause = 1'b0;
        prev_osd       = 1'b0;
        prev_key_reset = 1'b0;
        prev_gfx       = '0;
        forever begin
            wait (steps_applied != steps_checked);
            repeat (SETTLE_CYCLES) @(negedge clk_sys);
            check_step();
            steps_checked = steps_applied;
        end
    end

    initial begin : stimulus
        int   i;
        int   p;
        dir_t dir_seq [N_SEQ] = '{4'h1, 4'h9, 4'h8, 4'hc, 4'h6, 4'h0, 4'h3, 4'h2, 4'hf};
        rst         = 1'b1;
        four_way    = 1'b0;
        rot_control = 1'b0;
        flip        = 1'b0;
        clear_inputs();
        repeat (RESET_CYCLES) @(negedge clk_sys);
        for (p = 0; p < PLAYERS; p++) begin
            check_value($sformatf("game_joystick%0d", p + 1), {GAME_JOY_W{1'b1}}, game_joy_of(p));
        end
        check_value("game_coin", {PLAYERS{1'b1}}, game_coin);
        check_value("game_start", {PLAYERS{1'b1}}, game_start);
        check_value("game_service", 1'b1, game_service);
        check_value("game_pause", 1'b0, game_pause);
        check_value("soft_rst", 1'b0, soft_rst);
        check_value("gfx_en", {GFX_W{1'b1}}, gfx_en);
        rst = 1'b0;

        random_steps(N_PLAIN, 1'b0, 1'b0, 1'b0);
        random_steps(N_ROT, 1'b0, 1'b1, 1'b1);
        random_steps(N_ROT, 1'b0, 1'b1, 1'b0);
        // player 1 walks through single, diagonal and opposite presses
        for (i = 0; i < N_SEQ; i++) begin
            @(negedge clk_sys);
            drive_random();
            four_way = 1'b1;
            rot_control = 1'b0;
            board_joy[0][DIR_W-1:0] = dir_seq[i];
            launch_step();
        end
        random_steps(N_FOUR, 1'b1, 1'b0, 1'b0);

        // key and player 2 toggles, menu override, download clear
        pause_step(1'b0, 1'b0, 1'b0, 1'b0);
        pause_step(1'b1, 1'b0, 1'b0, 1'b0);
        pause_step(1'b0, 1'b0, 1'b0, 1'b0);
        pause_step(1'b0, 1'b1, 1'b0, 1'b0);
        pause_step(1'b0, 1'b0, 1'b1, 1'b0);
        pause_step(1'b1, 1'b0, 1'b1, 1'b0);
        pause_step(1'b0, 1'b0, 1'b0, 1'b0);
        pause_step(1'b1, 1'b0, 1'b1, 1'b0);
        pause_step(1'b0, 1'b0, 1'b1, 1'b1);
        pause_step(1'b1, 1'b1, 1'b1, 1'b1);
        pause_step(1'b0, 1'b0, 1'b1, 1'b0);
        pause_step(1'b1, 1'b0, 1'b1, 1'b0);

        random_steps(N_MIX, 1'b1, 1'b1, 1'b1);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the test steps did not complete in time, %0d errors so far", errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- project.f
src/board_pkg.sv
src/joy_4way.sv
src/joy_mapper.sv
src/board_ctrl.sv
src/input_board_top.sv
bench/tb_input_board.sv

//--- src/board_ctrl.sv
// board level control: pause state, soft reset pulse, debug layer enables
// also registers coin, start and service for the game with its polarity
// player bits come from the mapper sync registers

`timescale 1ns/1ps

module board_ctrl import board_pkg::*; #(
    parameter int ACTIVE_LOW = 1
) (
    input  logic               clk_sys,
    input  logic               rst,
    input  logic [PLAYERS-1:0] map_start,
    input  logic [PLAYERS-1:0] map_coin,
    input  logic [PLAYERS-1:0] map_pause,
    input  logic [PLAYERS-1:0] key_start,
    input  logic [PLAYERS-1:0] key_coin,
    input  logic               key_reset,
    input  logic               key_pause,
    input  logic               key_service,
    input  logic [GFX_W-1:0]   key_gfx,
    input  logic               osd_pause,
    input  logic               downloading,
    output logic [PLAYERS-1:0] game_coin,
    output logic [PLAYERS-1:0] game_start,
    output logic               game_service,
    output logic               game_pause,
    output logic               soft_rst,
    output logic [GFX_W-1:0]   gfx_en
);

    localparam bit INVERT = (ACTIVE_LOW != 0);

    // previous samples for edge detection
    logic             last_pause;
    logic             last_joypause;
    logic             last_osd_pause;
    logic             last_reset;
    logic [GFX_W-1:0] last_gfx;

    logic             joy_pause;
    logic             pause_toggle;
    logic             osd_change;
    logic [GFX_W-1:0] gfx_rise;

    // only players 1 and 2 can pause from the stick
    assign joy_pause    = map_pause[0] | map_pause[1];

    assign pause_toggle = (key_pause && !last_pause) || (joy_pause && !last_joypause);
    assign osd_change   = osd_pause ^ last_osd_pause;
    assign gfx_rise     = key_gfx & ~last_gfx;

    // history keeps sampling through reset so a held key gives no edge later
    always_ff @(posedge clk_sys) begin
        last_pause     <= key_pause;
        last_joypause  <= joy_pause;
        last_osd_pause <= osd_pause;
        last_reset     <= key_reset;
        last_gfx       <= key_gfx;
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause <= 1'b0;
        end else if (downloading) begin
            game_pause <= 1'b0;
        end else if (osd_change) begin
            // menu setting overrides a toggle in the same cycle
            game_pause <= osd_pause;
        end else if (pause_toggle) begin
            game_pause <= ~game_pause;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            soft_rst <= 1'b0;
        end else begin
            soft_rst <= key_reset && !last_reset;
        end
    end

    // all layers on after reset
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            gfx_en <= '1;
        end else begin
            gfx_en <= gfx_en ^ gfx_rise;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_coin    <= {PLAYERS{INVERT}};
            game_start   <= {PLAYERS{INVERT}};
            game_service <= INVERT;
        end else begin
            game_coin    <= {PLAYERS{INVERT}} ^ (map_coin | key_coin);
            game_start   <= {PLAYERS{INVERT}} ^ (map_start | key_start);
            game_service <= key_service ^ INVERT;
        end
    end

endmodule

//--- src/board_pkg.sv
// shared widths and joystick types for the player input board
// imported by every RTL module of the board with a wildcard import

package board_pkg;

    // player and layer counts
    localparam int PLAYERS    = 4;
    localparam int GFX_W      = 4;

    // joystick word widths
    localparam int JOY_W      = 16;
    localparam int GAME_JOY_W = 10;
    localparam int DIR_W      = 4;

    // direction bit positions inside every joystick word
    localparam int DIR_RIGHT  = 0;
    localparam int DIR_LEFT   = 1;
    localparam int DIR_DOWN   = 2;
    localparam int DIR_UP     = 3;

    // raw word from the board, active high
    typedef logic [JOY_W-1:0] joy_word_t;

    // word as the game core sees it
    typedef logic [GAME_JOY_W-1:0] game_joy_t;

    // right, left, down, up
    typedef logic [DIR_W-1:0] dir_t;

endpackage

//--- src/input_board_top.sv
// player input board top level
// one joystick mapper per player plus the shared control block
// BUTTONS and ACTIVE_LOW are set here for the whole board

`timescale 1ns/1ps

module input_board_top import board_pkg::*; #(
    parameter int BUTTONS    = 2,
    parameter int ACTIVE_LOW = 1
) (
    input  logic               clk_sys,
    input  logic               rst,
    input  joy_word_t          board_joystick1,
    input  joy_word_t          board_joystick2,
    input  joy_word_t          board_joystick3,
    input  joy_word_t          board_joystick4,
    input  game_joy_t          key_joy1,
    input  game_joy_t          key_joy2,
    input  game_joy_t          key_joy3,
    input  game_joy_t          key_joy4,
    input  logic [PLAYERS-1:0] key_start,
    input  logic [PLAYERS-1:0] key_coin,
    input  logic               key_reset,
    input  logic               key_pause,
    input  logic               key_service,
    input  logic [GFX_W-1:0]   key_gfx,
    input  logic               four_way,
    input  logic               rot_control,
    input  logic               flip,
    input  logic               osd_pause,
    input  logic               downloading,
    output game_joy_t          game_joystick1,
    output game_joy_t          game_joystick2,
    output game_joy_t          game_joystick3,
    output game_joy_t          game_joystick4,
    output logic [PLAYERS-1:0] game_coin,
    output logic [PLAYERS-1:0] game_start,
    output logic               game_service,
    output logic               game_pause,
    output logic               soft_rst,
    output logic [GFX_W-1:0]   gfx_en
);

    // per-player bits from the mapper sync registers, player 1 in bit 0
    logic [PLAYERS-1:0] map_start;
    logic [PLAYERS-1:0] map_coin;
    logic [PLAYERS-1:0] map_pause;

    joy_mapper #(.BUTTONS(BUTTONS), .ACTIVE_LOW(ACTIVE_LOW)) joy_mapper_p1_inst (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .board_joy   (board_joystick1),
        .key_joy     (key_joy1),
        .four_way    (four_way),
        .rot_control (rot_control),
        .flip        (flip),
        .game_joy    (game_joystick1),
        .start_bit   (map_start[0]),
        .coin_bit    (map_coin[0]),
        .pause_bit   (map_pause[0])
    );

    joy_mapper #(.BUTTONS(BUTTONS), .ACTIVE_LOW(ACTIVE_LOW)) joy_mapper_p2_inst (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .board_joy   (board_joystick2),
        .key_joy     (key_joy2),
        .four_way    (four_way),
        .rot_control (rot_control),
        .flip        (flip),
        .game_joy    (game_joystick2),
        .start_bit   (map_start[1]),
        .coin_bit    (map_coin[1]),
        .pause_bit   (map_pause[1])
    );

    joy_mapper #(.BUTTONS(BUTTONS), .ACTIVE_LOW(ACTIVE_LOW)) joy_mapper_p3_inst (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .board_joy   (board_joystick3),
        .key_joy     (key_joy3),
        .four_way    (four_way),
        .rot_control (rot_control),
        .flip        (flip),
        .game_joy    (game_joystick3),
        .start_bit   (map_start[2]),
        .coin_bit    (map_coin[2]),
        .pause_bit   (map_pause[2])
    );

    joy_mapper #(.BUTTONS(BUTTONS), .ACTIVE_LOW(ACTIVE_LOW)) joy_mapper_p4_inst (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .board_joy   (board_joystick4),
        .key_joy     (key_joy4),
        .four_way    (four_way),
        .rot_control (rot_control),
        .flip        (flip),
        .game_joy    (game_joystick4),
        .start_bit   (map_start[3]),
        .coin_bit    (map_coin[3]),
        .pause_bit   (map_pause[3])
    );

    board_ctrl #(.ACTIVE_LOW(ACTIVE_LOW)) board_ctrl_inst (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .map_start    (map_start),
        .map_coin     (map_coin),
        .map_pause    (map_pause),
        .key_start    (key_start),
        .key_coin     (key_coin),
        .key_reset    (key_reset),
        .key_pause    (key_pause),
        .key_service  (key_service),
        .key_gfx      (key_gfx),
        .osd_pause    (osd_pause),
        .downloading  (downloading),
        .game_coin    (game_coin),
        .game_start   (game_start),
        .game_service (game_service),
        .game_pause   (game_pause),
        .soft_rst     (soft_rst),
        .gfx_en       (gfx_en)
    );

endmodule

//--- src/joy_4way.sv
// turns an 8-way stick into a 4-way one for games that expect it
// diagonals resolve to the last single direction that was held
// one register stage in both modes

`timescale 1ns/1ps

module joy_4way import board_pkg::*; (
    input  logic clk_sys,
    input  logic rst,
    input  logic enable,
    input  dir_t dir_in,
    output dir_t dir_out
);

    // last direction seen pressed on its own, one-hot or zero
    dir_t last_dir;

    logic any_pressed;
    logic single_pressed;
    logic last_held;
    dir_t filtered;

    assign any_pressed    = dir_in != '0;
    assign single_pressed = any_pressed && ((dir_in & (dir_in - 1'b1)) == '0);
    assign last_held      = (dir_in & last_dir) != '0;

    always_comb begin
        if (single_pressed) begin
            filtered = dir_in;
        end else if (any_pressed && last_held) begin
            // diagonal that still includes the old direction
            filtered = last_dir;
        end else begin
            filtered = '0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_dir <= '0;
        end else if (enable && single_pressed) begin
            last_dir <= dir_in;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dir_out <= '0;
        end else if (enable) begin
            dir_out <= filtered;
        end else begin
            dir_out <= dir_in;
        end
    end

endmodule

//--- src/joy_mapper.sv
// joystick path of one player, from board word to game word
// stage 1 filters directions and delays the upper bits, stage 2 merges keys,
// stage 3 rotates for vertical screens and applies the output polarity

`timescale 1ns/1ps

module joy_mapper import board_pkg::*; #(
    parameter int BUTTONS    = 2,
    parameter int ACTIVE_LOW = 1
) (
    input  logic      clk_sys,
    input  logic      rst,
    input  joy_word_t board_joy,
    input  game_joy_t key_joy,
    input  logic      four_way,
    input  logic      rot_control,
    input  logic      flip,
    output game_joy_t game_joy,
    output logic      start_bit,
    output logic      coin_bit,
    output logic      pause_bit
);

    // start, coin and pause sit right after the buttons
    localparam int START_BIT = BUTTONS + 4;
    localparam int COIN_BIT  = BUTTONS + 5;
    localparam int PAUSE_BIT = BUTTONS + 6;

    localparam bit INVERT = (ACTIVE_LOW != 0);

    dir_t                   dir_q;
    logic [JOY_W-1:DIR_W]   upper_q;
    joy_word_t              sync_q;

    // directions as seen on a rotated cabinet
    function automatic game_joy_t rotate_dirs(
        input game_joy_t joy,
        input logic      rot,
        input logic      flip_sel
    );
        game_joy_t r;
        r = joy;
        if (rot) begin
            if (flip_sel) begin
                r[DIR_UP]    = joy[DIR_LEFT];
                r[DIR_DOWN]  = joy[DIR_RIGHT];
                r[DIR_LEFT]  = joy[DIR_DOWN];
                r[DIR_RIGHT] = joy[DIR_UP];
            end else begin
                r[DIR_UP]    = joy[DIR_RIGHT];
                r[DIR_DOWN]  = joy[DIR_LEFT];
                r[DIR_LEFT]  = joy[DIR_UP];
                r[DIR_RIGHT] = joy[DIR_DOWN];
            end
        end
        return r;
    endfunction

    joy_4way joy_4way_inst (
        .clk_sys (clk_sys),
        .rst     (rst),
        .enable  (four_way),
        .dir_in  (board_joy[DIR_W-1:0]),
        .dir_out (dir_q)
    );

    // upper bits wait one cycle to line up with the filter output
    always_ff @(posedge clk_sys) begin
        upper_q <= board_joy[JOY_W-1:DIR_W];
    end

    // keys only cover the low game bits
    always_ff @(posedge clk_sys) begin
        sync_q <= {upper_q, dir_q} | {{(JOY_W-GAME_JOY_W){1'b0}}, key_joy};
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joy <= {GAME_JOY_W{INVERT}};
        end else begin
            game_joy <= {GAME_JOY_W{INVERT}}
                      ^ rotate_dirs(sync_q[GAME_JOY_W-1:0], rot_control, flip);
        end
    end

    assign start_bit = sync_q[START_BIT];
    assign coin_bit  = sync_q[COIN_BIT];
    assign pause_bit = sync_q[PAUSE_BIT];

endmodule
